// File: cpu_pkg.sv
// ISA widths, word and index types, opcode encoding, link register and reset address
package cpu_pkg;

    localparam int data_w  = 16;
    localparam int instr_w = 16;
    localparam int reg_w   = 4;
    localparam int pc_w    = 12;

    typedef logic [data_w-1:0]  word_t;
    typedef logic [instr_w-1:0] instr_t;
    typedef logic [reg_w-1:0]   reg_idx_t;
    // instruction address, counted in words
    typedef logic [pc_w-1:0]    pc_t;

    // instruction layout is op[15:12] rd[11:8] rs[7:4] rt[3:0]
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_addi = 4'd5,
        op_ldi  = 4'd6,
        op_lw   = 4'd7,
        op_sw   = 4'd8,
        op_call = 4'd9,
        op_ret  = 4'd10,
        op_halt = 4'd11
    } opcode_t;

    // call writes its return address here, ret jumps through it
    localparam reg_idx_t link_reg = 4'd15;
    localparam pc_t      reset_pc = '0;

endpackage

// File: bus_pkg.sv
// Wishbone data-memory widths and address/data types
package bus_pkg;

    localparam int wb_adr_w = 16;
    localparam int wb_dat_w = 16;
    localparam int wb_sel_w = 2;

    // word address into data memory
    typedef logic [wb_adr_w-1:0] wb_adr_t;
    typedef logic [wb_dat_w-1:0] wb_dat_t;

endpackage

// File: hazard_unit.sv
// hazard FSM for decode-stage data stalls and call/return fetch holds
`timescale 1ns/1ps

module hazard_unit (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::reg_idx_t id_rs,
    input  cpu_pkg::reg_idx_t id_rt,
    input  cpu_pkg::reg_idx_t id_rd,
    input  logic              id_uses_rs,
    input  logic              id_uses_rt,
    input  logic              id_uses_rd,
    input  logic              id_is_call,
    input  logic              id_is_ret,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  cpu_pkg::reg_idx_t mem_rd,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  logic              ex_wr,
    input  logic              mem_wr,
    input  logic              wb_wr,
    input  logic              pc_update,
    output logic              data_hazard,
    output logic              pc_hazard
);

    typedef enum logic {
        st_run,
        st_wait_pc
    } state_t;

    state_t state;
    logic   rs_hit;
    logic   rt_hit;
    logic   rd_hit;

    // a source is pending while any later stage still has to write it
    assign rs_hit = id_uses_rs && (id_rs != '0) &&
                    ((ex_wr && id_rs == ex_rd) || (mem_wr && id_rs == mem_rd) ||
                     (wb_wr && id_rs == wb_rd));
    assign rt_hit = id_uses_rt && (id_rt != '0) &&
                    ((ex_wr && id_rt == ex_rd) || (mem_wr && id_rt == mem_rd) ||
                     (wb_wr && id_rt == wb_rd));
    assign rd_hit = id_uses_rd && (id_rd != '0) &&
                    ((ex_wr && id_rd == ex_rd) || (mem_wr && id_rd == mem_rd) ||
                     (wb_wr && id_rd == wb_rd));

    assign data_hazard = (state == st_run) && (rs_hit || rt_hit || rd_hit);
    assign pc_hazard   = (state == st_wait_pc);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_run;
        end else begin
            case (state)
                st_run: begin
                    // a ret still waiting on r15 must not leave decode yet
                    if ((id_is_call || id_is_ret) && !data_hazard) begin
                        state <= st_wait_pc;
                    end
                end
                st_wait_pc: begin
                    if (pc_update) begin
                        state <= st_run;
                    end
                end
                default: state <= st_run;
            endcase
        end
    end

endmodule

// File: pc_counter.sv
// program counter with sequential fetch, stall and halt hold, redirect load
`timescale 1ns/1ps

module pc_counter (
    input  logic         clk,
    input  logic         rst,
    input  logic         data_hazard,
    input  logic         pc_hazard,
    input  logic         mem_busy,
    input  logic         halted,
    input  logic         pc_update,
    input  cpu_pkg::pc_t redirect_pc,
    output cpu_pkg::pc_t pc
);

    logic fetch_hold;

    assign fetch_hold = data_hazard || pc_hazard || mem_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= cpu_pkg::reset_pc;
        end else if (pc_update) begin
            // resolved call or return target wins over any hold
            pc <= redirect_pc;
        end else if (!fetch_hold && !halted) begin
            pc <= pc + cpu_pkg::pc_t'(1);
        end
    end

endmodule

// File: reg_file.sv
// 16x16 register file, three combinational reads, one write, r0 tied to zero
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  cpu_pkg::reg_idx_t rs_idx,
    input  cpu_pkg::reg_idx_t rt_idx,
    input  cpu_pkg::reg_idx_t rd_idx,
    output cpu_pkg::word_t    rs_val,
    output cpu_pkg::word_t    rt_val,
    output cpu_pkg::word_t    rd_val,
    input  logic              wr_en,
    input  cpu_pkg::reg_idx_t wr_idx,
    input  cpu_pkg::word_t    wr_data
);

    // r0 has no storage
    cpu_pkg::word_t regs [1:15];

    assign rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_val = (rt_idx == '0) ? '0 : regs[rt_idx];
    // rd port feeds store data
    assign rd_val = (rd_idx == '0) ? '0 : regs[rd_idx];

    // no write-through, a reader sees the value one cycle after writeback
    always_ff @(posedge clk) begin
        if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// File: decode_stage.sv
// IF/ID register, instruction field decode, source-use flags and ID/EX register
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::instr_t   imem_data,
    input  cpu_pkg::pc_t      pc,
    input  logic              data_hazard,
    input  logic              pc_hazard,
    input  logic              mem_busy,
    output cpu_pkg::reg_idx_t id_rs,
    output cpu_pkg::reg_idx_t id_rt,
    output cpu_pkg::reg_idx_t id_rd,
    output logic              id_uses_rs,
    output logic              id_uses_rt,
    output logic              id_uses_rd,
    output logic              id_is_call,
    output logic              id_is_ret,
    input  cpu_pkg::word_t    rs_val,
    input  cpu_pkg::word_t    rt_val,
    input  cpu_pkg::word_t    rd_val,
    output cpu_pkg::opcode_t  ex_op,
    output cpu_pkg::word_t    ex_a,
    output cpu_pkg::word_t    ex_b,
    output cpu_pkg::word_t    ex_store,
    output logic [11:0]       ex_imm,
    output cpu_pkg::pc_t      ex_link_pc,
    output cpu_pkg::reg_idx_t ex_rd,
    output logic              ex_wr
);

    cpu_pkg::instr_t  if_instr;
    cpu_pkg::pc_t     if_pc;
    logic             if_valid;
    logic             id_valid;
    cpu_pkg::opcode_t id_op;
    logic             writes_rd;
    logic [11:0]      id_imm;

    // IF/ID, held on a data stall, emptied while a redirect is pending
    always_ff @(posedge clk) begin
        if (rst) begin
            if_valid <= 1'b0;
        end else if (!mem_busy && !data_hazard) begin
            if_valid <= !pc_hazard;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy && !data_hazard) begin
            if_instr <= imem_data;
            if_pc    <= pc;
        end
    end

    // whatever sits in decode behind a call or ret is on the wrong path
    assign id_valid = if_valid && !pc_hazard;
    assign id_op    = cpu_pkg::opcode_t'(if_instr[15:12]);
    assign id_rd    = if_instr[11:8];
    assign id_rt    = if_instr[3:0];
    assign id_rs    = (id_op == cpu_pkg::op_ret) ? cpu_pkg::link_reg : if_instr[7:4];

    // only report a call/ret in the cycle it can actually move on
    assign id_is_call = id_valid && !mem_busy && (id_op == cpu_pkg::op_call);
    assign id_is_ret  = id_valid && !mem_busy && (id_op == cpu_pkg::op_ret);

    always_comb begin
        id_uses_rs = 1'b0;
        id_uses_rt = 1'b0;
        id_uses_rd = 1'b0;
        writes_rd  = 1'b0;
        id_imm     = {8'h00, if_instr[3:0]};
        if (id_valid) begin
            case (id_op)
                cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or: begin
                    id_uses_rs = 1'b1;
                    id_uses_rt = 1'b1;
                    writes_rd  = 1'b1;
                end
                cpu_pkg::op_addi, cpu_pkg::op_lw: begin
                    id_uses_rs = 1'b1;
                    writes_rd  = 1'b1;
                end
                cpu_pkg::op_ldi: begin
                    writes_rd = 1'b1;
                    id_imm    = {4'h0, if_instr[7:0]};
                end
                cpu_pkg::op_sw: begin
                    // rd names the register being stored
                    id_uses_rs = 1'b1;
                    id_uses_rd = 1'b1;
                end
                cpu_pkg::op_call: begin
                    writes_rd = 1'b1;
                    id_imm    = if_instr[11:0];
                end
                cpu_pkg::op_ret: begin
                    id_uses_rs = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // ID/EX, a bubble goes in on a stall or an empty slot
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_op <= cpu_pkg::op_nop;
            ex_wr <= 1'b0;
        end else if (!mem_busy) begin
            if (id_valid && !data_hazard) begin
                ex_op <= id_op;
                ex_wr <= writes_rd;
            end else begin
                ex_op <= cpu_pkg::op_nop;
                ex_wr <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            ex_a       <= rs_val;
            ex_b       <= rt_val;
            ex_store   <= rd_val;
            ex_imm     <= id_imm;
            ex_link_pc <= if_pc + cpu_pkg::pc_t'(1);
            ex_rd      <= (id_op == cpu_pkg::op_call) ? cpu_pkg::link_reg : id_rd;
        end
    end

endmodule

// File: exec_stage.sv
// ALU, load/store address, call/return target and EX/MEM register
`timescale 1ns/1ps

module exec_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_busy,
    input  cpu_pkg::opcode_t  ex_op,
    input  cpu_pkg::word_t    ex_a,
    input  cpu_pkg::word_t    ex_b,
    input  cpu_pkg::word_t    ex_store,
    input  logic [11:0]       ex_imm,
    input  cpu_pkg::pc_t      ex_link_pc,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  logic              ex_wr,
    output logic              pc_update,
    output cpu_pkg::pc_t      redirect_pc,
    output cpu_pkg::opcode_t  mem_op,
    output cpu_pkg::word_t    mem_result,
    output cpu_pkg::word_t    mem_store,
    output cpu_pkg::reg_idx_t mem_rd,
    output logic              mem_wr
);

    cpu_pkg::word_t imm_ext;
    cpu_pkg::word_t alu_res;
    logic           is_jump;

    assign imm_ext = {4'h0, ex_imm};
    assign is_jump = (ex_op == cpu_pkg::op_call) || (ex_op == cpu_pkg::op_ret);

    always_comb begin
        case (ex_op)
            cpu_pkg::op_add:  alu_res = ex_a + ex_b;
            cpu_pkg::op_sub:  alu_res = ex_a - ex_b;
            cpu_pkg::op_and:  alu_res = ex_a & ex_b;
            cpu_pkg::op_or:   alu_res = ex_a | ex_b;
            // addi, lw and sw all use rs plus the unsigned rt field
            cpu_pkg::op_addi, cpu_pkg::op_lw, cpu_pkg::op_sw: alu_res = ex_a + imm_ext;
            cpu_pkg::op_ldi:  alu_res = imm_ext;
            // return address, written to r15
            cpu_pkg::op_call: alu_res = {4'h0, ex_link_pc};
            default:          alu_res = '0;
        endcase
    end

    // pc_update is high only while the call or ret sits in MEM
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_op    <= cpu_pkg::op_nop;
            mem_wr    <= 1'b0;
            pc_update <= 1'b0;
        end else if (!mem_busy) begin
            mem_op    <= ex_op;
            mem_wr    <= ex_wr;
            pc_update <= is_jump;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            mem_result  <= alu_res;
            mem_store   <= ex_store;
            mem_rd      <= ex_rd;
            redirect_pc <= (ex_op == cpu_pkg::op_ret) ? ex_a[11:0] : ex_imm;
        end
    end

endmodule

// File: mem_stage.sv
// Wishbone classic master for loads and stores, MEM/WB register and halt latch
`timescale 1ns/1ps

module mem_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  cpu_pkg::opcode_t            mem_op,
    input  cpu_pkg::word_t              mem_result,
    input  cpu_pkg::word_t              mem_store,
    input  cpu_pkg::reg_idx_t           mem_rd,
    input  logic                        mem_wr,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output bus_pkg::wb_adr_t            wb_adr,
    output bus_pkg::wb_dat_t            wb_dat_o,
    output logic [bus_pkg::wb_sel_w-1:0] wb_sel,
    input  bus_pkg::wb_dat_t            wb_dat_i,
    input  logic                        wb_ack,
    output logic                        mem_busy,
    output cpu_pkg::reg_idx_t           wb_rd,
    output logic                        wb_wr,
    output cpu_pkg::word_t              wb_data,
    output logic                        halted
);

    logic cyc_q;
    logic is_load;
    logic mem_req;

    assign is_load = (mem_op == cpu_pkg::op_lw);
    // nothing behind a halt may reach the bus
    assign mem_req = (is_load || mem_op == cpu_pkg::op_sw) && !halted;

    // stays busy from the cycle the access enters MEM until ack
    assign mem_busy = mem_req && !(cyc_q && wb_ack);

    // EX/MEM is frozen while busy, so these hold until ack
    assign wb_cyc   = cyc_q;
    assign wb_stb   = cyc_q;
    assign wb_we    = (mem_op == cpu_pkg::op_sw);
    assign wb_adr   = bus_pkg::wb_adr_t'(mem_result);
    assign wb_dat_o = bus_pkg::wb_dat_t'(mem_store);
    assign wb_sel   = '1;

    // cyc drops in the cycle after ack, so transfers never run back to back
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q <= 1'b0;
        end else if (cyc_q && wb_ack) begin
            cyc_q <= 1'b0;
        end else if (mem_req) begin
            cyc_q <= 1'b1;
        end
    end

    // MEM/WB, a waiting access leaves a bubble in writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_wr  <= 1'b0;
            halted <= 1'b0;
        end else begin
            wb_wr <= mem_wr && !mem_busy && !halted;
            if (mem_op == cpu_pkg::op_halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            wb_rd   <= mem_rd;
            wb_data <= is_load ? cpu_pkg::word_t'(wb_dat_i) : mem_result;
        end
    end

endmodule

// File: pipe_core.sv
// top level of the five-stage core, stage and hazard unit interconnect
`timescale 1ns/1ps

module pipe_core (
    input  logic                        clk,
    input  logic                        rst,
    output cpu_pkg::pc_t                imem_addr,
    input  cpu_pkg::instr_t             imem_data,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output bus_pkg::wb_adr_t            wb_adr,
    output bus_pkg::wb_dat_t            wb_dat_o,
    output logic [bus_pkg::wb_sel_w-1:0] wb_sel,
    input  bus_pkg::wb_dat_t            wb_dat_i,
    input  logic                        wb_ack,
    output logic                        halted
);

    // stall and redirect control
    logic data_hazard;
    logic pc_hazard;
    logic mem_busy;
    logic pc_update;
    cpu_pkg::pc_t redirect_pc;

    // decode to hazard unit and register file
    cpu_pkg::reg_idx_t id_rs;
    cpu_pkg::reg_idx_t id_rt;
    cpu_pkg::reg_idx_t id_rd;
    logic id_uses_rs;
    logic id_uses_rt;
    logic id_uses_rd;
    logic id_is_call;
    logic id_is_ret;
    cpu_pkg::word_t rs_val;
    cpu_pkg::word_t rt_val;
    cpu_pkg::word_t rd_val;

    // ID/EX
    cpu_pkg::opcode_t ex_op;
    cpu_pkg::word_t ex_a;
    cpu_pkg::word_t ex_b;
    cpu_pkg::word_t ex_store;
    logic [11:0] ex_imm;
    cpu_pkg::pc_t ex_link_pc;
    cpu_pkg::reg_idx_t ex_rd;
    logic ex_wr;

    // EX/MEM
    cpu_pkg::opcode_t mem_op;
    cpu_pkg::word_t mem_result;
    cpu_pkg::word_t mem_store;
    cpu_pkg::reg_idx_t mem_rd;
    logic mem_wr;

    // MEM/WB write port
    cpu_pkg::reg_idx_t wb_rd;
    logic wb_wr;
    cpu_pkg::word_t wb_data;

    // fetch address goes straight to the instruction port
    pc_counter u_pc_counter (
        .pc(imem_addr),
        .*
    );

    decode_stage u_decode_stage (
        .pc(imem_addr),
        .*
    );

    reg_file u_reg_file (
        .clk(clk),
        .rs_idx(id_rs),
        .rt_idx(id_rt),
        .rd_idx(id_rd),
        .rs_val(rs_val),
        .rt_val(rt_val),
        .rd_val(rd_val),
        .wr_en(wb_wr),
        .wr_idx(wb_rd),
        .wr_data(wb_data)
    );

    hazard_unit u_hazard_unit (.*);

    exec_stage u_exec_stage (.*);

    mem_stage u_mem_stage (.*);

endmodule

// File: pipe_core_props.sv
// Wishbone protocol and hazard output assertions, bound into pipe_core
`timescale 1ns/1ps

module pipe_core_props (
    input logic             clk,
    input logic             rst,
    input logic             wb_cyc,
    input logic             wb_stb,
    input logic             wb_we,
    input bus_pkg::wb_adr_t wb_adr,
    input bus_pkg::wb_dat_t wb_dat_o,
    input logic             wb_ack,
    input logic             halted,
    input logic             data_hazard,
    input logic             pc_hazard
);

    // a classic cycle closes in the cycle after ack
    a_cyc_after_ack: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && wb_ack) |=> (!wb_stb && !wb_cyc))
        else $error("Wishbone cycle still open after ack");

    // request holds still until the slave acks
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=>
        (wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o)))
        else $error("Wishbone request changed before ack");

    a_reset_quiet: assert property (@(posedge clk) rst |=> (!data_hazard && !pc_hazard))
        else $error("hazard output high after a reset cycle");

    a_halt_idle: assert property (@(posedge clk) disable iff (rst) halted |-> !wb_cyc)
        else $error("Wishbone cycle while halted");

endmodule

bind pipe_core pipe_core_props u_props (.*);

// File: tb_pipe_core.sv
// directed testbench for pipe_core with instruction array, Wishbone memory model and LFSR
`timescale 1ns/1ps

module tb_pipe_core;

    logic                         clk;
    logic                         rst;
    cpu_pkg::pc_t                 imem_addr;
    cpu_pkg::instr_t              imem_data;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    bus_pkg::wb_adr_t             wb_adr;
    bus_pkg::wb_dat_t             wb_dat_o;
    logic [bus_pkg::wb_sel_w-1:0] wb_sel;
    bus_pkg::wb_dat_t             wb_dat_i;
    logic                         wb_ack;
    logic                         halted;

    cpu_pkg::instr_t imem [0:4095];
    cpu_pkg::word_t  dmem [0:255];
    // stores seen on the bus, and the stores a test expects
    logic [15:0] log_adr [$];
    logic [15:0] log_dat [$];
    logic [15:0] exp_adr [$];
    logic [15:0] exp_dat [$];

    logic [31:0] lfsr_state = 32'hd38b_7a65;
    int ack_wait = -1;
    int checks = 0;
    int errors = 0;
    int timeouts = 0;

    pipe_core u_dut (
        .clk(clk),
        .rst(rst),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o),
        .wb_sel(wb_sel),
        .wb_dat_i(wb_dat_i),
        .wb_ack(wb_ack),
        .halted(halted)
    );

    always #5 clk = ~clk;

    // instruction port answers in the same cycle
    assign imem_data = imem[imem_addr];

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic cpu_pkg::instr_t encode(input cpu_pkg::opcode_t op,
                                               input logic [3:0] rd, input logic [3:0] rs,
                                               input logic [3:0] rt);
        encode = {op, rd, rs, rt};
    endfunction

    function automatic cpu_pkg::instr_t load_imm(input logic [3:0] rd, input logic [7:0] imm);
        load_imm = {cpu_pkg::op_ldi, rd, imm};
    endfunction

    function automatic cpu_pkg::instr_t call_to(input logic [11:0] target);
        call_to = {cpu_pkg::op_call, target};
    endfunction

    // upper byte scrambled from the full word address
    function automatic cpu_pkg::word_t dmem_fill(input logic [7:0] a);
        dmem_fill = {a ^ 8'hc3, a};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Wishbone slave, ack after 0 to 3 wait cycles
    always @(posedge clk) begin
        #1;
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (ack_wait < 0) begin
                random_bits(2, ack_wait);
            end
            if (ack_wait == 0) begin
                check_value("wb_sel", 32'(wb_sel), 32'h3);
                if (wb_we) begin
                    dmem[wb_adr[7:0]] = wb_dat_o;
                    log_adr.push_back(wb_adr);
                    log_dat.push_back(wb_dat_o);
                end else begin
                    wb_dat_i = dmem[wb_adr[7:0]];
                end
                wb_ack = 1'b1;
                ack_wait = -1;
            end else begin
                ack_wait--;
            end
        end
    end

    task automatic clear_program();
        for (int a = 0; a < 4096; a++) begin
            imem[a] = '0;
        end
        for (int a = 0; a < 256; a++) begin
            dmem[a] = dmem_fill(a[7:0]);
        end
        log_adr.delete();
        log_dat.delete();
        exp_adr.delete();
        exp_dat.delete();
    endtask

    task automatic expect_write(input logic [15:0] adr, input logic [15:0] dat);
        exp_adr.push_back(adr);
        exp_dat.push_back(dat);
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic wait_halted(input int limit);
        int n;
        n = 0;
        while (halted !== 1'b1 && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (halted !== 1'b1) begin
            timeouts++;
            $display("timeout: halted did not rise within %0d cycles", limit);
        end
    endtask

    task automatic check_writes(input string name);
        check_value({name, " store count"}, log_adr.size(), exp_adr.size());
        for (int i = 0; i < exp_adr.size() && i < log_adr.size(); i++) begin
            check_value($sformatf("%s wb_adr[%0d]", name, i), log_adr[i], exp_adr[i]);
            check_value($sformatf("%s wb_dat_o[%0d]", name, i), log_dat[i], exp_dat[i]);
        end
    endtask

    task automatic run_program(input string name);
        reset_dut();
        wait_halted(600);
        check_writes(name);
    endtask

    task automatic reset_defaults();
        clear_program();
        imem[0] = encode(cpu_pkg::op_halt, 0, 0, 0);
        reset_dut();
        check_value("imem_addr", imem_addr, 0);
        check_value("wb_cyc", wb_cyc, 0);
        check_value("halted", halted, 0);
        wait_halted(100);
        check_writes("reset");
    endtask

    task automatic alu_dependency_chain();
        cpu_pkg::word_t sum;
        cpu_pkg::word_t diff;
        cpu_pkg::word_t both;
        cpu_pkg::word_t either;
        clear_program();
        imem[0]  = load_imm(1, 8'h35);
        imem[1]  = load_imm(2, 8'h1c);
        imem[2]  = encode(cpu_pkg::op_add, 3, 1, 2);
        imem[3]  = encode(cpu_pkg::op_sub, 4, 3, 1);
        imem[4]  = encode(cpu_pkg::op_and, 5, 4, 3);
        imem[5]  = load_imm(7, 8'hc2);
        imem[6]  = encode(cpu_pkg::op_or, 6, 5, 7);
        // r0 as a source, result wraps below zero
        imem[7]  = encode(cpu_pkg::op_sub, 8, 0, 6);
        imem[8]  = load_imm(9, 8'h40);
        imem[9]  = encode(cpu_pkg::op_sw, 3, 9, 0);
        imem[10] = encode(cpu_pkg::op_sw, 4, 9, 1);
        imem[11] = encode(cpu_pkg::op_sw, 5, 9, 2);
        imem[12] = encode(cpu_pkg::op_sw, 6, 9, 3);
        imem[13] = encode(cpu_pkg::op_sw, 8, 9, 4);
        imem[14] = encode(cpu_pkg::op_halt, 0, 0, 0);
        sum    = 16'h0035 + 16'h001c;
        diff   = sum - 16'h0035;
        both   = diff & sum;
        either = both | 16'h00c2;
        expect_write(16'h0040, sum);
        expect_write(16'h0041, diff);
        expect_write(16'h0042, both);
        expect_write(16'h0043, either);
        expect_write(16'h0044, 16'h0000 - either);
        run_program("alu chain");
    endtask

    task automatic load_store_random_ack();
        for (int round = 0; round < 3; round++) begin
            clear_program();
            imem[0]  = load_imm(1, 8'h20);
            imem[1]  = encode(cpu_pkg::op_lw, 2, 1, 0);
            imem[2]  = encode(cpu_pkg::op_addi, 2, 2, 1);
            imem[3]  = load_imm(3, 8'h60);
            imem[4]  = encode(cpu_pkg::op_sw, 2, 3, 0);
            imem[5]  = encode(cpu_pkg::op_lw, 4, 1, 9);
            imem[6]  = encode(cpu_pkg::op_addi, 4, 4, 15);
            imem[7]  = encode(cpu_pkg::op_sw, 4, 3, 7);
            // overwrite a preset word, then read it back
            imem[8]  = encode(cpu_pkg::op_sw, 2, 1, 2);
            imem[9]  = encode(cpu_pkg::op_lw, 5, 1, 2);
            imem[10] = encode(cpu_pkg::op_addi, 5, 5, 2);
            imem[11] = encode(cpu_pkg::op_sw, 5, 3, 1);
            imem[12] = encode(cpu_pkg::op_halt, 0, 0, 0);
            expect_write(16'h0060, dmem_fill(8'h20) + 16'd1);
            expect_write(16'h0067, dmem_fill(8'h29) + 16'd15);
            expect_write(16'h0022, dmem_fill(8'h20) + 16'd1);
            expect_write(16'h0061, dmem_fill(8'h20) + 16'd3);
            run_program($sformatf("load store round %0d", round));
        end
    endtask

    task automatic call_and_return();
        clear_program();
        imem[0]  = load_imm(1, 8'h70);
        imem[1]  = load_imm(2, 8'hbb);
        imem[2]  = call_to(12'h008);
        // a store right behind the call, only legal after the return
        imem[3]  = encode(cpu_pkg::op_sw, 2, 1, 1);
        imem[4]  = encode(cpu_pkg::op_halt, 0, 0, 0);
        // subroutine
        imem[8]  = load_imm(3, 8'haa);
        imem[9]  = encode(cpu_pkg::op_sw, 3, 1, 0);
        imem[10] = encode(cpu_pkg::op_sw, 15, 1, 3);
        imem[11] = encode(cpu_pkg::op_ret, 0, 0, 0);
        // wrong path behind the ret, must never store
        imem[12] = encode(cpu_pkg::op_sw, 3, 1, 2);
        imem[13] = encode(cpu_pkg::op_halt, 0, 0, 0);
        expect_write(16'h0070, 16'h00aa);
        // link value is the word after the call
        expect_write(16'h0073, 16'h0003);
        expect_write(16'h0071, 16'h00bb);
        run_program("call return");
    endtask

    task automatic halt_blocks_bus();
        int n;
        clear_program();
        imem[0] = load_imm(1, 8'h50);
        imem[1] = load_imm(2, 8'h3c);
        imem[2] = encode(cpu_pkg::op_sw, 2, 1, 0);
        imem[3] = encode(cpu_pkg::op_halt, 0, 0, 0);
        imem[4] = encode(cpu_pkg::op_sw, 2, 1, 1);
        imem[5] = encode(cpu_pkg::op_sw, 2, 1, 2);
        imem[6] = encode(cpu_pkg::op_sw, 1, 1, 3);
        expect_write(16'h0050, 16'h003c);
        run_program("halt");
        n = 0;
        while (n < 40) begin
            @(posedge clk);
            #1;
            check_value("wb_cyc after halt", wb_cyc, 0);
            n++;
        end
        check_value("halted", halted, 1);
        check_value("store count after halt", log_adr.size(), 1);
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        wb_ack   = 1'b0;
        wb_dat_i = '0;
        clear_program();
        reset_defaults();
        alu_dependency_chain();
        load_store_random_ack();
        call_and_return();
        halt_blocks_bus();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: pipe_core.f
cpu_pkg.sv
bus_pkg.sv
hazard_unit.sv
pc_counter.sv
reg_file.sv
decode_stage.sv
exec_stage.sv
mem_stage.sv
pipe_core.sv
pipe_core_props.sv
tb_pipe_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_pipe_core \
    -f pipe_core.f --Mdir obj_dir -o sim_pipe_core > build.log 2>&1 \
    && ./obj_dir/sim_pipe_core > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
